/* source/lsu_pkg.sv */
package lsu_pkg;

    // Access width as encoded by the issue stage
    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_t;

    // What the load formatter needs to know about the op in the memory stage
    typedef struct packed {
        mem_width_t width;
        logic       is_unsigned;
        logic [2:0] byte_off;
    } mem_op_t;

    // Data memory geometry, one entry per 64-bit word
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

endpackage

/* source/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;

    // Request, a single-cycle strobe
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wmask;
    logic        wen;
    logic        valid;

    // Read data, one cycle after a read request
    logic [63:0] rdata;

    modport fmt (
        output addr,
        output wdata,
        output wmask
    );

    modport ctrl (
        output valid,
        output wen
    );

    modport mem (
        input  addr,
        input  wdata,
        input  wmask,
        input  wen,
        input  valid,
        output rdata
    );

endinterface

/* source/lsu_store_format.sv */
`timescale 1ns/1ps

module lsu_store_format (
    input  logic                [63:0] issue_base,
    input  logic                [11:0] issue_offset,
    input  logic                [63:0] issue_source,
    input  lsu_pkg::mem_width_t        issue_width,
    input  logic                       issue_unsigned,
    dmem_if.fmt                        dmem,
    output logic                       unaligned,
    output lsu_pkg::mem_op_t           op
);
    import lsu_pkg::*;

    logic [63:0] addr;
    logic [2:0]  off;

    assign addr = issue_base + {{52{issue_offset[11]}}, issue_offset};
    assign off  = addr[2:0];

    // Natural alignment by width, bytes are always aligned
    always_comb begin
        case (issue_width)
            MW_HALF:   unaligned = off[0];
            MW_WORD:   unaligned = (off[1:0] != 2'b00);
            MW_DOUBLE: unaligned = (off != 3'b000);
            default:   unaligned = 1'b0;
        endcase
    end

    // Copy the store value into every lane so the mask alone picks the bytes
    always_comb begin
        case (issue_width)
            MW_BYTE: begin
                dmem.wdata = {8{issue_source[7:0]}};
                dmem.wmask = 8'b0000_0001 << off;
            end
            MW_HALF: begin
                dmem.wdata = {4{issue_source[15:0]}};
                dmem.wmask = 8'b0000_0011 << {off[2:1], 1'b0};
            end
            MW_WORD: begin
                dmem.wdata = {2{issue_source[31:0]}};
                dmem.wmask = 8'b0000_1111 << {off[2], 2'b00};
            end
            default: begin
                dmem.wdata = issue_source;
                dmem.wmask = 8'hff;
            end
        endcase
    end

    assign dmem.addr = addr;

    assign op.width       = issue_width;
    assign op.is_unsigned = issue_unsigned;
    assign op.byte_off    = off;

endmodule

/* source/lsu_load_format.sv */
`timescale 1ns/1ps

module lsu_load_format (
    input  logic             clk,
    input  logic             rst,
    input  logic [63:0]      rdata,
    input  lsu_pkg::mem_op_t m_op,
    input  logic             advance,
    output logic [63:0]      wb_result
);
    import lsu_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;
    logic [63:0] result;

    // Lanes picked by the low address bits of the op
    assign lane_b = rdata[{m_op.byte_off, 3'b000} +: 8];
    assign lane_h = rdata[{m_op.byte_off[2:1], 4'b0000} +: 16];
    assign lane_w = rdata[{m_op.byte_off[2], 5'b00000} +: 32];

    always_comb begin
        case (m_op.width)
            MW_BYTE: begin
                if (m_op.is_unsigned) begin
                    result = {56'd0, lane_b};
                end else begin
                    result = {{56{lane_b[7]}}, lane_b};
                end
            end
            MW_HALF: begin
                if (m_op.is_unsigned) begin
                    result = {48'd0, lane_h};
                end else begin
                    result = {{48{lane_h[15]}}, lane_h};
                end
            end
            MW_WORD: begin
                if (m_op.is_unsigned) begin
                    result = {32'd0, lane_w};
                end else begin
                    result = {{32{lane_w[31]}}, lane_w};
                end
            end
            default: result = rdata;
        endcase
    end

    // Stores pass through here too, their result is never used
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_result <= 64'd0;
        end else if (advance) begin
            wb_result <= result;
        end
    end

endmodule

/* source/lsu_dmem.sv */
`timescale 1ns/1ps

module lsu_dmem (
    input logic  clk,
    dmem_if.mem  dmem
);
    import lsu_pkg::*;

    logic [63:0]        mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic               wr;
    logic               rd;

    // Word index from bits 3 up, upper address bits are ignored
    assign idx = dmem.addr[3 +: DMEM_AW];

    assign wr = dmem.valid && dmem.wen;
    assign rd = dmem.valid && !dmem.wen;

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (wr) begin
            for (int i = 0; i < 8; i++) begin
                if (dmem.wmask[i]) begin
                    mem[idx][i*8 +: 8] <= dmem.wdata[i*8 +: 8];
                end
            end
        end
    end

    // rdata keeps the last read word until the next read
    always_ff @(posedge clk) begin
        if (rd) begin
            dmem.rdata <= mem[idx];
        end
    end

endmodule

/* source/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  logic             issue_speculate,
    input  logic             abort,
    input  logic             wb_ready,
    input  logic             issue_wb_en,
    input  logic [63:0]      issue_pc,
    input  logic [4:0]       issue_dst,
    input  logic             unaligned,
    input  lsu_pkg::mem_op_t op,
    output logic             issue_ready,
    dmem_if.ctrl             dmem,
    output lsu_pkg::mem_op_t m_op,
    output logic             advance,
    output logic             wb_valid,
    output logic [63:0]      wb_pc,
    output logic [4:0]       wb_dst,
    output logic             wb_wb_en,
    output logic             unaligned_load,
    output logic             unaligned_store,
    output logic [63:0]      unaligned_epc
);
    import lsu_pkg::*;

    logic        accept;
    logic        go;
    logic        exc;
    logic        stall;
    logic        m_valid;
    logic        m_spec;
    logic        m_kill;
    logic        m_cancel;
    logic [63:0] m_pc;
    logic [4:0]  m_dst;
    logic        m_wb_en;
    mem_op_t     m_op_r;

    // Both stages full and the writeback register not being taken
    assign stall = m_valid && wb_valid && !wb_ready;

    assign issue_ready = !rst && !stall;
    assign accept      = issue_valid && issue_ready;

    // Aborted or unaligned ops are taken off the port but go no further
    assign go  = accept && !abort && !unaligned;
    assign exc = accept && !abort && unaligned;

    // Memory is accessed in the address cycle
    assign dmem.valid = go;
    assign dmem.wen   = !issue_wb_en;

    // Memory stage moves on when the writeback register is free or emptying
    assign advance = m_valid && (!wb_valid || wb_ready);

    // Abort counts against a speculative op only in the cycle right after acceptance
    assign m_cancel = m_kill || (m_spec && abort);

    assign m_op = m_op_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid         <= 1'b0;
            m_spec          <= 1'b0;
            m_kill          <= 1'b0;
            wb_valid        <= 1'b0;
            unaligned_load  <= 1'b0;
            unaligned_store <= 1'b0;
        end else begin
            if (go) begin
                m_valid <= 1'b1;
            end else if (advance) begin
                m_valid <= 1'b0;
            end

            m_spec <= go && issue_speculate;

            // Remember a late abort while the op waits for writeback
            if (go || advance) begin
                m_kill <= 1'b0;
            end else if (m_cancel) begin
                m_kill <= 1'b1;
            end

            if (advance) begin
                wb_valid <= !m_cancel;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;
            end

            // One-cycle exception pulses
            unaligned_load  <= exc && issue_wb_en;
            unaligned_store <= exc && !issue_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            m_pc    <= issue_pc;
            m_dst   <= issue_dst;
            m_wb_en <= issue_wb_en;
            m_op_r  <= op;
        end
        if (advance) begin
            wb_pc    <= m_pc;
            wb_dst   <= m_dst;
            wb_wb_en <= m_wb_en;
        end
        if (exc) begin
            unaligned_epc <= issue_pc;
        end
    end

endmodule

/* source/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue_valid,
    output logic                       issue_ready,
    input  logic                [63:0] issue_pc,
    input  logic                [4:0]  issue_dst,
    input  logic                       issue_wb_en,
    input  logic                [63:0] issue_base,
    input  logic                [11:0] issue_offset,
    input  logic                [63:0] issue_source,
    input  logic                       issue_unsigned,
    input  lsu_pkg::mem_width_t        issue_width,
    input  logic                       issue_speculate,
    input  logic                       abort,
    output logic                       wb_valid,
    input  logic                       wb_ready,
    output logic                [63:0] wb_pc,
    output logic                [4:0]  wb_dst,
    output logic                [63:0] wb_result,
    output logic                       wb_wb_en,
    output logic                       unaligned_load,
    output logic                       unaligned_store,
    output logic                [63:0] unaligned_epc
);
    import lsu_pkg::*;

    dmem_if  dmem_bus ();

    logic    unaligned;
    logic    advance;
    mem_op_t op;
    mem_op_t m_op;

    lsu_store_format store_fmt0 (
        .issue_base     (issue_base),
        .issue_offset   (issue_offset),
        .issue_source   (issue_source),
        .issue_width    (issue_width),
        .issue_unsigned (issue_unsigned),
        .dmem           (dmem_bus.fmt),
        .unaligned      (unaligned),
        .op             (op)
    );

    lsu_ctrl ctrl0 (
        .clk             (clk),
        .rst             (rst),
        .issue_valid     (issue_valid),
        .issue_speculate (issue_speculate),
        .abort           (abort),
        .wb_ready        (wb_ready),
        .issue_wb_en     (issue_wb_en),
        .issue_pc        (issue_pc),
        .issue_dst       (issue_dst),
        .unaligned       (unaligned),
        .op              (op),
        .issue_ready     (issue_ready),
        .dmem            (dmem_bus.ctrl),
        .m_op            (m_op),
        .advance         (advance),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_dst          (wb_dst),
        .wb_wb_en        (wb_wb_en),
        .unaligned_load  (unaligned_load),
        .unaligned_store (unaligned_store),
        .unaligned_epc   (unaligned_epc)
    );

    lsu_dmem dmem0 (
        .clk  (clk),
        .dmem (dmem_bus.mem)
    );

    lsu_load_format load_fmt0 (
        .clk       (clk),
        .rst       (rst),
        .rdata     (dmem_bus.rdata),
        .m_op      (m_op),
        .advance   (advance),
        .wb_result (wb_result)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

/* bench/lsu_assertions.sv */
`timescale 1ns/1ps

module lsu_assertions (
    input logic        clk,
    input logic        rst,
    input logic        wb_valid,
    input logic        wb_ready,
    input logic [63:0] wb_pc,
    input logic [4:0]  wb_dst,
    input logic [63:0] wb_result,
    input logic        wb_wb_en,
    input logic        unaligned_load,
    input logic        unaligned_store
);

    int fail_count = 0;

    // A stalled writeback keeps all its fields
    hold_wb: assert property (@(posedge clk) disable iff (rst)
            wb_valid && !wb_ready |=> wb_valid && $stable(wb_pc) && $stable(wb_dst)
            && $stable(wb_result) && $stable(wb_wb_en))
        else begin
            fail_count++;
            $error("wb fields changed while wb_ready was low");
        end

    pulse_load: assert property (@(posedge clk) disable iff (rst)
            unaligned_load |=> !unaligned_load)
        else begin
            fail_count++;
            $error("unaligned_load stayed high for more than one cycle");
        end

    pulse_store: assert property (@(posedge clk) disable iff (rst)
            unaligned_store |=> !unaligned_store)
        else begin
            fail_count++;
            $error("unaligned_store stayed high for more than one cycle");
        end

    reset_wb: assert property (@(posedge clk) rst |=> !wb_valid)
        else begin
            fail_count++;
            $error("wb_valid high during reset");
        end

endmodule

/* bench/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker (
    input logic                clk,
    input logic                rst,
    input logic                issue_valid,
    input logic                issue_ready,
    input logic [63:0]         issue_pc,
    input logic [4:0]          issue_dst,
    input logic                issue_wb_en,
    input logic [63:0]         issue_base,
    input logic [11:0]         issue_offset,
    input logic [63:0]         issue_source,
    input logic                issue_unsigned,
    input lsu_pkg::mem_width_t issue_width,
    input logic                issue_speculate,
    input logic                abort,
    input logic                wb_valid,
    input logic                wb_ready,
    input logic [63:0]         wb_pc,
    input logic [4:0]          wb_dst,
    input logic [63:0]         wb_result,
    input logic                wb_wb_en,
    input logic                unaligned_load,
    input logic                unaligned_store,
    input logic [63:0]         unaligned_epc
);
    import lsu_pkg::*;

    localparam int BYTE_AW     = DMEM_AW + 3;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  dst;
        logic        is_load;
        logic [63:0] result;
        logic [31:0] accepted_at;
    } wb_exp_t;

    // Byte-wide reference memory, same wrap as the DUT
    logic [7:0]  ref_mem [DMEM_WORDS*8];
    wb_exp_t     wb_q[$];
    logic [64:0] exc_q[$];
    string       test_name = "reset";
    logic        lat_check = 1'b0;
    logic        spec_last = 1'b0;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          first_errors = 0;
    int          tests = 0;

    // Bytes at addr, extended to 64 bits as a load of width w returns them
    function automatic logic [63:0] expected_load(logic [63:0] addr, mem_width_t w, logic uns);
        logic [63:0] value;
        int          n;
        value = 64'd0;
        n = 1 << w;
        for (int i = 0; i < n; i++) begin
            value[i*8 +: 8] = ref_mem[addr[BYTE_AW-1:0] + i];
        end
        if (!uns && n < 8 && value[n*8-1]) begin
            value = value | (~64'd0 << (n*8));
        end
        return value;
    endfunction

    task automatic apply_store(logic [63:0] addr, mem_width_t w, logic [63:0] src);
        for (int i = 0; i < (1 << w); i++) begin
            ref_mem[addr[BYTE_AW-1:0] + i] = src[i*8 +: 8];
        end
    endtask

    task automatic compare(string field, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_writeback();
        wb_exp_t entry;
        if (wb_q.size() == 0) begin
            $display("Unexpected writeback for pc %h in test %s", wb_pc, test_name);
            errors++;
            return;
        end
        entry = wb_q.pop_front();
        compare("wb_pc", entry.pc, wb_pc);
        compare("wb_dst", 64'(entry.dst), 64'(wb_dst));
        compare("wb_wb_en", 64'(entry.is_load), 64'(wb_wb_en));
        if (entry.is_load) begin
            compare("wb_result", entry.result, wb_result);
        end
        if (lat_check) begin
            compare("latency", 64'd2, 64'(cycle - entry.accepted_at));
        end
    endtask

    task automatic check_exception();
        logic [64:0] entry;
        if (exc_q.size() == 0) begin
            $display("Unexpected exception pulse for pc %h in test %s", unaligned_epc, test_name);
            errors++;
            return;
        end
        entry = exc_q.pop_front();
        compare("unaligned_load", 64'(entry[64]), 64'(unaligned_load));
        compare("unaligned_store", 64'(!entry[64]), 64'(unaligned_store));
        compare("unaligned_epc", entry[63:0], unaligned_epc);
    endtask

    // Everything is sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        logic [63:0] addr;
        wb_exp_t     entry;
        cycle++;
        if (!rst) begin
            // Abort right after a speculative op cancels its writeback
            if (spec_last && abort) begin
                entry = wb_q.pop_back();
            end
            spec_last = 1'b0;
            if (issue_valid && issue_ready && !abort) begin
                addr = issue_base + {{52{issue_offset[11]}}, issue_offset};
                if (addr % (1 << issue_width) != 0) begin
                    exc_q.push_back({issue_wb_en, issue_pc});
                end else begin
                    entry.pc          = issue_pc;
                    entry.dst         = issue_dst;
                    entry.is_load     = issue_wb_en;
                    entry.result      = expected_load(addr, issue_width, issue_unsigned);
                    entry.accepted_at = cycle;
                    if (!issue_wb_en) begin
                        apply_store(addr, issue_width, issue_source);
                    end
                    wb_q.push_back(entry);
                    spec_last = issue_speculate;
                end
            end
            if (wb_valid && wb_ready) begin
                check_writeback();
            end
            if (unaligned_load || unaligned_store) begin
                check_exception();
            end
        end
    end

    task automatic begin_test(string name, logic lat);
        test_name    = name;
        lat_check    = lat;
        first_errors = errors;
    endtask

    // Waits for every expected event, then a few cycles for stray ones
    task automatic end_test();
        int waited;
        waited = 0;
        while ((wb_q.size() != 0 || exc_q.size() != 0) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        repeat (4) @(negedge clk);
        #1;
        if (wb_q.size() != 0 || exc_q.size() != 0) begin
            $display("Test %s: %0d writebacks and %0d exception pulses never arrived",
                     test_name, wb_q.size(), exc_q.size());
            errors += wb_q.size() + exc_q.size();
            wb_q.delete();
            exc_q.delete();
        end
        tests++;
        $display("Test %s finished with %0d errors", test_name, errors - first_errors);
    endtask

    task automatic report();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

endmodule

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_FILL    = DMEM_WORDS;
    localparam int N_STORE   = 32;
    localparam int N_LOAD    = 64;
    localparam int N_MASK    = 16;
    localparam int N_UNAL    = 12;
    localparam int N_ABORT   = 8;
    localparam int N_BP      = 48;
    localparam int N_B2B     = 16;
    localparam int TOTAL_OPS = N_FILL + N_STORE + N_LOAD + 2 * N_MASK + 2 * N_UNAL
                               + 3 * N_ABORT + N_BP + N_B2B;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 1500;

    logic        clk, rst;
    logic        issue_valid, issue_ready, issue_wb_en, issue_unsigned, issue_speculate;
    logic [63:0] issue_pc, issue_base, issue_source;
    logic [4:0]  issue_dst;
    logic [11:0] issue_offset;
    mem_width_t  issue_width;
    logic        abort;
    logic        wb_valid, wb_ready, wb_wb_en;
    logic [63:0] wb_pc, wb_result;
    logic [4:0]  wb_dst;
    logic        unaligned_load, unaligned_store;
    logic [63:0] unaligned_epc;

    integer      seed = 98;
    logic [63:0] next_pc;
    logic        bp_pattern [512];
    logic        bp_on = 1'b0;
    int          bp_idx = 0;

    tb_clock clk_gen0 (.clk(clk));

    lsu_top dut0 (.*);

    lsu_checker chk0 (.*);

    bind lsu_top lsu_assertions asrt0 (.*);

    function automatic logic [63:0] rand64();
        logic [63:0] v;
        v[31:0]  = $random(seed);
        v[63:32] = $random(seed);
        return v;
    endfunction

    function automatic mem_width_t rand_width();
        logic [31:0] r;
        r = $random(seed);
        return mem_width_t'(r[1:0]);
    endfunction

    function automatic logic [63:0] rand_addr(mem_width_t w);
        return rand64() & (~64'd0 << w);
    endfunction

    // Initial memory contents, a hash of the whole address
    function automatic logic [63:0] fill_word(logic [63:0] a);
        return {a[31:0], a[63:32]} ^ (a * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    // Offer one op and hold it until the DUT takes it
    task automatic issue_op(logic is_load, mem_width_t w, logic uns, logic [63:0] addr,
                            logic spec, logic abrt, logic [63:0] data);
        logic [11:0] off;
        logic        taken;
        off             = $random(seed);
        issue_dst       = $random(seed);
        issue_valid     = 1'b1;
        issue_pc        = next_pc;
        next_pc         = next_pc + 4;
        issue_wb_en     = is_load;
        issue_width     = w;
        issue_unsigned  = uns;
        issue_offset    = off;
        issue_base      = addr - {{52{off[11]}}, off};
        issue_source    = data;
        issue_speculate = spec;
        abort           = abrt;
        taken           = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = issue_ready;
            @(posedge clk);
            #10;
        end
        abort           = 1'b0;
        issue_speculate = 1'b0;
    endtask

    // Abort in the cycle after a speculative op
    task automatic kill_last();
        issue_valid = 1'b0;
        abort       = 1'b1;
        @(posedge clk);
        #10;
        abort = 1'b0;
    endtask

    task automatic finish_test(logic bp_next);
        issue_valid = 1'b0;
        chk0.end_test();
        bp_on = bp_next;
        @(posedge clk);
        #10;
    endtask

    // wb_ready follows the stored pattern while back-pressure is on
    always begin
        @(posedge clk);
        #10;
        if (bp_on) begin
            wb_ready = bp_pattern[bp_idx];
            bp_idx   = (bp_idx + 1) % 512;
        end else begin
            wb_ready = 1'b1;
        end
    end

    initial begin
        mem_width_t  w;
        logic [63:0] a;
        logic [31:0] r;
        rst             = 1'b1;
        issue_valid     = 1'b0;
        issue_pc        = 64'd0;
        issue_dst       = 5'd0;
        issue_wb_en     = 1'b0;
        issue_base      = 64'd0;
        issue_offset    = 12'd0;
        issue_source    = 64'd0;
        issue_unsigned  = 1'b0;
        issue_width     = MW_BYTE;
        issue_speculate = 1'b0;
        abort           = 1'b0;
        wb_ready        = 1'b1;
        next_pc         = 64'h8000_0000;
        for (int i = 0; i < 512; i++) begin
            r = $random(seed);
            bp_pattern[i] = r[0];
        end
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        chk0.begin_test("store_load", 1'b0);
        for (int i = 0; i < N_FILL; i++) begin
            a = i * 8;
            issue_op(1'b0, MW_DOUBLE, 1'b0, a, 1'b0, 1'b0, fill_word(a));
        end
        for (int i = 0; i < N_STORE; i++) begin
            w = rand_width();
            issue_op(1'b0, w, 1'b0, rand_addr(w), 1'b0, 1'b0, rand64());
        end
        for (int i = 0; i < N_LOAD; i++) begin
            w = rand_width();
            r = $random(seed);
            issue_op(1'b1, w, r[0], rand_addr(w), 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b0);

        // Sub-word store, then the whole word back
        chk0.begin_test("byte_mask", 1'b0);
        for (int i = 0; i < N_MASK; i++) begin
            w = rand_width();
            if (w == MW_DOUBLE) begin
                w = MW_BYTE;
            end
            a = rand_addr(w);
            issue_op(1'b0, w, 1'b0, a, 1'b0, 1'b0, rand64());
            issue_op(1'b1, MW_DOUBLE, 1'b0, a & ~64'd7, 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b0);

        chk0.begin_test("unaligned", 1'b0);
        for (int i = 0; i < N_UNAL; i++) begin
            w = rand_width();
            if (w == MW_BYTE) begin
                w = MW_HALF;
            end
            a = rand_addr(MW_BYTE);
            if (a == (a & (~64'd0 << w))) begin
                a = a + 1;
            end
            r = $random(seed);
            issue_op(r[0], w, 1'b0, a, 1'b0, 1'b0, rand64());
            issue_op(1'b1, MW_DOUBLE, 1'b0, a & ~64'd7, 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b0);

        chk0.begin_test("abort", 1'b0);
        for (int i = 0; i < N_ABORT; i++) begin
            a = rand_addr(MW_DOUBLE);
            r = $random(seed);
            issue_op(r[0], MW_DOUBLE, 1'b0, a, 1'b0, 1'b1, rand64());
            issue_op(1'b1, MW_WORD, 1'b0, a, 1'b1, 1'b0, 64'd0);
            kill_last();
            issue_op(1'b1, MW_DOUBLE, 1'b0, a, 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b1);

        chk0.begin_test("back_pressure", 1'b0);
        for (int i = 0; i < N_BP; i++) begin
            w = rand_width();
            r = $random(seed);
            issue_op(1'b1, w, r[0], rand_addr(w), 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b0);

        chk0.begin_test("back_to_back", 1'b1);
        for (int i = 0; i < N_B2B; i++) begin
            issue_op(1'b1, MW_DOUBLE, 1'b0, rand_addr(MW_DOUBLE), 1'b0, 1'b0, 64'd0);
        end
        finish_test(1'b0);

        chk0.report();
        if (chk0.errors == 0 && dut0.asrt0.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* all.f */
source/lsu_pkg.sv
source/dmem_if.sv
source/lsu_store_format.sv
source/lsu_load_format.sv
source/lsu_dmem.sv
source/lsu_ctrl.sv
source/lsu_top.sv
bench/tb_clock.sv
bench/lsu_assertions.sv
bench/lsu_checker.sv
bench/lsu_tb.sv
